/* source/wiscPkg.sv */
package wiscPkg;

    localparam int dataW    = 16;
    localparam int regAddrW = 3;

    typedef enum logic [4:0] {
        opHalt   = 5'b00000,
        opNop    = 5'b00001,
        opJ      = 5'b00100,
        opJr     = 5'b00101,
        opJal    = 5'b00110,
        opJalr   = 5'b00111,
        opAddi   = 5'b01000,
        opSubi   = 5'b01001,
        opXori   = 5'b01010,
        opAndni  = 5'b01011,
        opBeqz   = 5'b01100,
        opBnez   = 5'b01101,
        opBltz   = 5'b01110,
        opBgez   = 5'b01111,
        opSt     = 5'b10000,
        opLd     = 5'b10001,
        opSlbi   = 5'b10010,
        opRoli   = 5'b10100,
        opSlli   = 5'b10101,
        opRori   = 5'b10110,
        opSrli   = 5'b10111,
        opLbi    = 5'b11000,
        opRShift = 5'b11010, // ROL SLL ROR SRL by funct
        opRArith = 5'b11011, // ADD SUB XOR ANDN by funct
        opSeq    = 5'b11100,
        opSlt    = 5'b11101,
        opSle    = 5'b11110,
        opSco    = 5'b11111
    } opcodeE;

    // Low two bits line up with the opcode and funct fields
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluAndn,
        aluRol, aluSll, aluRor, aluSrl,
        aluEq, aluLt, aluLe, aluCo,
        aluPassB, aluSlbi
    } aluOpE;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPc, wbCmp} wbSelE;
    typedef enum logic [1:0] {bSelRt, bSelImm5, bSelImm8} bSelE;
    typedef enum logic [1:0] {dstI1Rd, dstRRd, dstRs, dstR7} dstSelE;

    typedef enum logic [2:0] {
        brNone, brBeqz, brBnez, brBltz, brBgez, brJump, brReg
    } branchCondE;

    typedef union packed {
        struct packed {
            logic [4:0]          opcode;
            logic [regAddrW-1:0] rs;
            logic [regAddrW-1:0] rt;
            logic [regAddrW-1:0] rd;
            logic [1:0]          funct;
        } rFmt;
        struct packed {
            logic [4:0]          opcode;
            logic [regAddrW-1:0] rs;
            logic [regAddrW-1:0] rd;
            logic [4:0]          imm5;
        } i1Fmt;
        struct packed {
            logic [4:0]          opcode;
            logic [regAddrW-1:0] rs;
            logic [7:0]          imm8;
        } i2Fmt;
        struct packed {
            logic [4:0]  opcode;
            logic [10:0] disp11;
        } jFmt;
    } instrU;

endpackage

/* source/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf;

    wiscPkg::aluOpE      aluOp;
    wiscPkg::bSelE       bSel;
    logic                zeroExt;    // Immediate extension mode
    wiscPkg::dstSelE     dstSel;
    logic                regWrEn;
    wiscPkg::wbSelE      wbSel;
    logic                memRdEn;
    logic                memWrEn;
    wiscPkg::branchCondE branchCond;
    logic                illegal;

    modport dec (output aluOp, bSel, zeroExt, dstSel, regWrEn, wbSel,
                 memRdEn, memWrEn, branchCond, illegal);

    modport exe (input aluOp, bSel, zeroExt, dstSel, regWrEn, wbSel,
                 memRdEn, memWrEn);

    modport pc (input branchCond, illegal);

endinterface

/* source/control.sv */
`timescale 1ns/1ps

module control (
    input  wiscPkg::instrU instr,
    output logic           haltOp,
    ctrlIf.dec             ctl
);

    logic [4:0] opBits;
    logic [1:0] funct;

    assign opBits = instr.rFmt.opcode;
    assign funct  = instr.rFmt.funct;

    always_comb begin
        haltOp         = 1'b0;
        ctl.aluOp      = wiscPkg::aluAdd;
        ctl.bSel       = wiscPkg::bSelRt;
        ctl.zeroExt    = 1'b0;
        ctl.dstSel     = wiscPkg::dstI1Rd;
        ctl.regWrEn    = 1'b0;
        ctl.wbSel      = wiscPkg::wbAlu;
        ctl.memRdEn    = 1'b0;
        ctl.memWrEn    = 1'b0;
        ctl.branchCond = wiscPkg::brNone;
        ctl.illegal    = 1'b0;

        case (opBits)
            wiscPkg::opHalt: haltOp = 1'b1;
            wiscPkg::opNop: begin
            end
            wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni: begin
                ctl.aluOp   = wiscPkg::aluOpE'({2'b00, opBits[1:0]});
                ctl.bSel    = wiscPkg::bSelImm5;
                ctl.zeroExt = opBits[1];           // XORI and ANDNI zero extend
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli: begin
                ctl.aluOp   = wiscPkg::aluOpE'({2'b01, opBits[1:0]});
                ctl.bSel    = wiscPkg::bSelImm5;
                ctl.zeroExt = 1'b1;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opSt: begin
                ctl.bSel    = wiscPkg::bSelImm5;   // Address is Rs plus imm5
                ctl.memWrEn = 1'b1;
            end
            wiscPkg::opLd: begin
                ctl.bSel    = wiscPkg::bSelImm5;
                ctl.memRdEn = 1'b1;
                ctl.wbSel   = wiscPkg::wbMem;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opSlbi: begin
                ctl.aluOp   = wiscPkg::aluSlbi;
                ctl.bSel    = wiscPkg::bSelImm8;
                ctl.zeroExt = 1'b1;
                ctl.dstSel  = wiscPkg::dstRs;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opLbi: begin
                ctl.aluOp   = wiscPkg::aluPassB;
                ctl.bSel    = wiscPkg::bSelImm8;
                ctl.dstSel  = wiscPkg::dstRs;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opRShift: begin
                ctl.aluOp   = wiscPkg::aluOpE'({2'b01, funct});
                ctl.dstSel  = wiscPkg::dstRRd;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opRArith: begin
                ctl.aluOp   = wiscPkg::aluOpE'({2'b00, funct});
                ctl.dstSel  = wiscPkg::dstRRd;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opSeq, wiscPkg::opSlt, wiscPkg::opSle, wiscPkg::opSco: begin
                ctl.aluOp   = wiscPkg::aluOpE'({2'b10, opBits[1:0]});
                ctl.dstSel  = wiscPkg::dstRRd;
                ctl.wbSel   = wiscPkg::wbCmp;
                ctl.regWrEn = 1'b1;
            end
            wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz, wiscPkg::opBgez: begin
                // Branch rules follow brNone in opcode order
                ctl.branchCond = wiscPkg::branchCondE'({1'b0, opBits[1:0]} + 3'd1);
            end
            wiscPkg::opJ: ctl.branchCond = wiscPkg::brJump;
            wiscPkg::opJr: ctl.branchCond = wiscPkg::brReg;
            wiscPkg::opJal, wiscPkg::opJalr: begin
                ctl.branchCond = opBits[0] ? wiscPkg::brReg : wiscPkg::brJump;
                ctl.dstSel     = wiscPkg::dstR7;   // Link register
                ctl.wbSel      = wiscPkg::wbPc;
                ctl.regWrEn    = 1'b1;
            end
            default: ctl.illegal = 1'b1;           // STU BTR siic RTI and unknown
        endcase
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [wiscPkg::regAddrW-1:0] rdAddrA,
    input  logic [wiscPkg::regAddrW-1:0] rdAddrB,
    input  logic [wiscPkg::regAddrW-1:0] wrAddr,
    input  logic [wiscPkg::dataW-1:0]    wrData,
    input  logic                         wrEn,
    output logic [wiscPkg::dataW-1:0]    rdDataA,
    output logic [wiscPkg::dataW-1:0]    rdDataB
);

    logic [wiscPkg::dataW-1:0] regs [2**wiscPkg::regAddrW];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see the value before this edge's write
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    // Decoder and execute together must produce a known index
    wrAddrKnown: assert property (@(posedge clk) disable iff (!arstN)
        wrEn |-> !$isunknown(wrAddr))
        else $error("regFile: write to unknown register index");

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  wiscPkg::instrU                instr,
    ctrlIf.exe                            ctl,
    input  logic [wiscPkg::dataW-1:0]     rdDataA,
    input  logic [wiscPkg::dataW-1:0]     rdDataB,
    input  logic [wiscPkg::dataW-1:0]     pcPlus2,
    input  logic [wiscPkg::dataW-1:0]     dmemRdData,
    input  logic                          running,
    output logic [wiscPkg::regAddrW-1:0]  rdAddrA,
    output logic [wiscPkg::regAddrW-1:0]  rdAddrB,
    output logic [wiscPkg::regAddrW-1:0]  wrAddr,
    output logic [wiscPkg::dataW-1:0]     wrData,
    output logic                          wrEn,
    output logic [wiscPkg::dataW-1:0]     rsValue,
    output logic [wiscPkg::dataW-1:0]     jumpTarget,
    output logic [wiscPkg::dataW-1:0]     dmemAddr,
    output logic [wiscPkg::dataW-1:0]     dmemWrData,
    output logic                          dmemWrEn,
    output logic                          dmemRdEn
);

    localparam int W = wiscPkg::dataW;

    logic [W-1:0]   imm5Ext, imm8Ext, opA, opB, aluResult;
    logic [W:0]     sum;
    logic [2*W-1:0] rolWord, rorWord;
    logic [3:0]     shAmt;
    logic           cmpFlag;

    assign rdAddrA = instr.rFmt.rs;
    assign rdAddrB = instr.rFmt.rt;                // Also Rd of ST, same bits

    assign imm5Ext = ctl.zeroExt ? {{(W-5){1'b0}}, instr.i1Fmt.imm5}
                                 : {{(W-5){instr.i1Fmt.imm5[4]}}, instr.i1Fmt.imm5};
    assign imm8Ext = ctl.zeroExt ? {{(W-8){1'b0}}, instr.i2Fmt.imm8}
                                 : {{(W-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};

    assign opA = rdDataA;
    always_comb begin
        case (ctl.bSel)
            wiscPkg::bSelImm5: opB = imm5Ext;
            wiscPkg::bSelImm8: opB = imm8Ext;
            default:           opB = rdDataB;
        endcase
    end

    assign shAmt   = opB[3:0];
    assign sum     = {1'b0, opA} + {1'b0, opB};    // Carry kept for SCO
    assign rolWord = {opA, opA} << shAmt;
    assign rorWord = {opA, opA} >> shAmt;

    always_comb begin
        case (ctl.aluOp)
            wiscPkg::aluAdd:   aluResult = sum[W-1:0];
            wiscPkg::aluSub:   aluResult = opB - opA;
            wiscPkg::aluXor:   aluResult = opA ^ opB;
            wiscPkg::aluAndn:  aluResult = opA & ~opB;
            wiscPkg::aluRol:   aluResult = rolWord[2*W-1:W];
            wiscPkg::aluSll:   aluResult = opA << shAmt;
            wiscPkg::aluRor:   aluResult = rorWord[W-1:0];
            wiscPkg::aluSrl:   aluResult = opA >> shAmt;
            wiscPkg::aluPassB: aluResult = opB;
            wiscPkg::aluSlbi:  aluResult = {opA[7:0], opB[7:0]};
            default:           aluResult = '0;
        endcase
    end

    always_comb begin
        case (ctl.aluOp)
            wiscPkg::aluEq: cmpFlag = (opA == opB);
            wiscPkg::aluLt: cmpFlag = ($signed(opA) < $signed(opB));
            wiscPkg::aluLe: cmpFlag = ($signed(opA) <= $signed(opB));
            wiscPkg::aluCo: cmpFlag = sum[W];
            default:        cmpFlag = 1'b0;
        endcase
    end

    always_comb begin
        case (ctl.dstSel)
            wiscPkg::dstRRd: wrAddr = instr.rFmt.rd;
            wiscPkg::dstRs:  wrAddr = instr.rFmt.rs;
            wiscPkg::dstR7:  wrAddr = '1;
            default:         wrAddr = instr.i1Fmt.rd;
        endcase
    end

    always_comb begin
        case (ctl.wbSel)
            wiscPkg::wbMem: wrData = dmemRdData;
            wiscPkg::wbPc:  wrData = pcPlus2;       // Link value
            wiscPkg::wbCmp: wrData = {{(W-1){1'b0}}, cmpFlag};
            default:        wrData = aluResult;
        endcase
    end

    assign wrEn       = ctl.regWrEn & running;
    assign rsValue    = rdDataA;
    assign jumpTarget = rdDataA + {{(W-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};
    assign dmemAddr   = aluResult;
    assign dmemWrData = rdDataB;
    assign dmemWrEn   = ctl.memWrEn & running;
    assign dmemRdEn   = ctl.memRdEn & running;

endmodule

/* source/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit #(
    parameter logic [wiscPkg::dataW-1:0] resetPc = '0
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  wiscPkg::instrU            instr,
    ctrlIf.pc                         ctl,
    input  logic                      haltOp,
    input  logic [wiscPkg::dataW-1:0] rsValue,
    input  logic [wiscPkg::dataW-1:0] jumpTarget,
    output logic [wiscPkg::dataW-1:0] pc,
    output logic [wiscPkg::dataW-1:0] pcPlus2,
    output logic                      running,
    output logic                      halted,
    output logic                      err
);

    localparam int W = wiscPkg::dataW;

    logic [W-1:0] brOffset, jOffset, nextPc;
    logic         taken;

    assign pcPlus2  = pc + W'(2);
    assign brOffset = {{(W-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};
    assign jOffset  = {{(W-11){instr.jFmt.disp11[10]}}, instr.jFmt.disp11};

    always_comb begin
        case (ctl.branchCond)
            wiscPkg::brBeqz: taken = (rsValue == '0);
            wiscPkg::brBnez: taken = (rsValue != '0);
            wiscPkg::brBltz: taken = rsValue[W-1];   // Sign bit
            wiscPkg::brBgez: taken = !rsValue[W-1];
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctl.branchCond)
            wiscPkg::brJump: nextPc = pcPlus2 + jOffset;
            wiscPkg::brReg:  nextPc = jumpTarget;
            default:         nextPc = taken ? pcPlus2 + brOffset : pcPlus2;
        endcase
    end

    assign running = !halted;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= resetPc;
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (running) begin
            if (haltOp || ctl.illegal) begin
                halted <= 1'b1;                      // PC stays on the stopping instruction
                err    <= ctl.illegal;
            end else begin
                pc <= nextPc;
            end
        end
    end

    // Fetch must stay halfword aligned for the whole program run
    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        running |-> !pc[0])
        else $error("pcUnit: odd PC while running");

endmodule

/* source/wiscCore.sv */
`timescale 1ns/1ps

module wiscCore #(
    parameter logic [wiscPkg::dataW-1:0] resetPc = '0
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [wiscPkg::dataW-1:0] imemData,
    input  logic [wiscPkg::dataW-1:0] dmemRdData,
    output logic [wiscPkg::dataW-1:0] imemAddr,
    output logic [wiscPkg::dataW-1:0] dmemAddr,
    output logic [wiscPkg::dataW-1:0] dmemWrData,
    output logic                      dmemWrEn,
    output logic                      dmemRdEn,
    output logic                      halted,
    output logic                      err
);

    wiscPkg::instrU                instr;
    logic                          haltOp, wrEn, running;
    logic [wiscPkg::regAddrW-1:0]  rdAddrA, rdAddrB, wrAddr;
    logic [wiscPkg::dataW-1:0]     rdDataA, rdDataB, wrData;
    logic [wiscPkg::dataW-1:0]     rsValue, jumpTarget, pcPlus2;

    ctrlIf ctlBus ();

    assign instr = imemData;                   // One word, four formats

    control u_control (.instr(instr), .haltOp(haltOp), .ctl(ctlBus));

    regFile u_regFile (
        .clk(clk), .arstN(arstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    executeUnit u_executeUnit (
        .instr(instr), .ctl(ctlBus), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .pcPlus2(pcPlus2), .dmemRdData(dmemRdData), .running(running),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(wrAddr), .wrData(wrData),
        .wrEn(wrEn), .rsValue(rsValue), .jumpTarget(jumpTarget),
        .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn),
        .dmemRdEn(dmemRdEn)
    );

    pcUnit #(.resetPc(resetPc)) u_pcUnit (
        .clk(clk), .arstN(arstN), .instr(instr), .ctl(ctlBus), .haltOp(haltOp),
        .rsValue(rsValue), .jumpTarget(jumpTarget), .pc(imemAddr),
        .pcPlus2(pcPlus2), .running(running), .halted(halted), .err(err)
    );

endmodule

/* testbench/tbWiscCore.sv */
`timescale 1ns/1ps

module tbWiscCore;

    localparam int imemWords = 128;
    localparam logic [4:0] immOps [8] = '{wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori,
        wiscPkg::opAndni, wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli};
    localparam logic [4:0] cmpOps [4] = '{wiscPkg::opSeq, wiscPkg::opSlt, wiscPkg::opSle,
        wiscPkg::opSco};
    localparam logic [4:0] brOps [4] = '{wiscPkg::opBeqz, wiscPkg::opBnez, wiscPkg::opBltz,
        wiscPkg::opBgez};
    localparam logic [15:0] cmpA [5] = '{16'h1234, 16'h8000, 16'hFFFE, 16'hFFFF, 16'h7FFF};
    localparam logic [15:0] cmpB [5] = '{16'h1234, 16'h0001, 16'hFFFF, 16'h0001, 16'h8000};
    // Pairs per rule, first value takes the branch
    localparam logic [15:0] brVals [8] = '{16'h0000, 16'h0005, 16'h0009, 16'h0000,
        16'hFFFD, 16'h0007, 16'h0001, 16'h8000};

    logic        clk = 1'b0;
    logic        arstN;
    logic [15:0] imemData, dmemRdData, imemAddr, dmemAddr, dmemWrData;
    logic        dmemWrEn, dmemRdEn, halted, err;

    logic [15:0] imem [imemWords];
    logic [15:0] dmem [256];
    logic [15:0] prog [$];
    logic [15:0] expAddr [$], expData [$], seenAddr [$], seenData [$];
    logic [15:0] expLoad [$], seenLoad [$];
    logic [15:0] nextAddr = 16'h0000;                  // Byte address held in r6
    int          progWords = 0;
    int          cycles = 0;

    wiscCore #(.resetPc(16'h0000)) u_dut (
        .clk(clk), .arstN(arstN), .imemData(imemData), .dmemRdData(dmemRdData),
        .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
        .dmemWrEn(dmemWrEn), .dmemRdEn(dmemRdEn), .halted(halted), .err(err)
    );

    always #2 clk = ~clk;

    assign imemData   = imem[imemAddr[7:1]];           // Word indexed, bit 0 ignored
    assign dmemRdData = dmem[dmemAddr[8:1]];

    always @(posedge clk) begin
        if (arstN && dmemWrEn) begin
            seenAddr.push_back(dmemAddr);
            seenData.push_back(dmemWrData);
            dmem[dmemAddr[8:1]] <= dmemWrData;
        end
        if (arstN && dmemRdEn) begin
            seenLoad.push_back(dmemAddr);
        end
    end

    // Limit grows with every program that is loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 12 * progWords + 200) begin
            $display("Timeout: the core never halted after %0d cycles", cycles);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    task automatic checkEq(input logic [15:0] actual, input logic [15:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [15:0] encI1(logic [4:0] op, logic [2:0] rs, logic [2:0] rd,
                                          logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] encI2(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] encR(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
                                         logic [2:0] rd, logic [1:0] funct);
        return {op, rs, rt, rd, funct};
    endfunction

    function automatic logic [15:0] encJ(logic [4:0] op, logic [10:0] disp);
        return {op, disp};
    endfunction

    function automatic logic [15:0] fillWord(logic [7:0] idx);
        return {~idx, idx ^ 8'hC3};
    endfunction

    // Kinds 0 to 7 are ADD SUB XOR ANDN ROL SLL ROR SRL
    function automatic logic [15:0] aluModel(int kind, logic [15:0] a, logic [15:0] b);
        logic [15:0] r;
        r = a;
        case (kind)
            0: r = a + b;
            1: r = b - a;                              // B minus A
            2: r = a ^ b;
            3: r = a & ~b;
            4: repeat (b[3:0]) r = {r[14:0], r[15]};
            5: r = a << b[3:0];
            6: repeat (b[3:0]) r = {r[0], r[15:1]};
            default: r = a >> b[3:0];
        endcase
        return r;
    endfunction

    function automatic logic compareModel(int kind, logic [15:0] a, logic [15:0] b);
        logic [16:0] wide;
        wide = {1'b0, a} + {1'b0, b};
        case (kind)
            0: return a == b;
            1: return $signed(a) < $signed(b);
            2: return $signed(a) <= $signed(b);
            default: return wide[16];                  // Carry out
        endcase
    endfunction

    function automatic logic branchTaken(int kind, logic [15:0] v);
        case (kind)
            0: return v == 16'h0000;
            1: return v != 16'h0000;
            2: return v[15];
            default: return !v[15];
        endcase
    endfunction

    function automatic logic [15:0] pcNext();
        return 16'(prog.size() * 2);
    endfunction

    task automatic emit(input logic [15:0] word);
        prog.push_back(word);
    endtask

    task automatic loadConst(input logic [2:0] r, input logic [15:0] v);
        emit(encI2(wiscPkg::opLbi, r, v[15:8]));
        emit(encI2(wiscPkg::opSlbi, r, v[7:0]));
    endtask

    task automatic storeRaw(input logic [2:0] r);
        emit(encI1(wiscPkg::opSt, 3'd6, r, 5'd0));
    endtask

    // Store at r6 and step r6 to the next word
    task automatic storeResult(input logic [2:0] r, input logic [15:0] expected);
        storeRaw(r);
        emit(encI1(wiscPkg::opAddi, 3'd6, 3'd6, 5'd2));
        expAddr.push_back(nextAddr);
        expData.push_back(expected);
        nextAddr = nextAddr + 16'd2;
    endtask

    task automatic runProgram(input logic expErr);
        logic [15:0] pcAtHalt;
        int i;
        @(negedge clk);
        arstN = 1'b0;
        emit({wiscPkg::opHalt, 11'd0});
        for (i = 0; i < imemWords; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 16'h0000;
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] <= fillWord(8'(i));
        end
        progWords += prog.size();
        seenAddr.delete();
        seenData.delete();
        seenLoad.delete();
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        while (!halted) @(negedge clk);
        pcAtHalt = imemAddr;
        repeat (4) @(negedge clk);                     // No commits after the stop
        checkEq(imemAddr, pcAtHalt, "PC frozen after halt");
        checkEq(16'(halted), 16'd1, "halted level");
        checkEq(16'(err), 16'(expErr), "err level");
        checkEq(16'(seenAddr.size()), 16'(expAddr.size()), "store count");
        for (i = 0; i < expAddr.size(); i++) begin
            checkEq(seenAddr[i], expAddr[i], $sformatf("store %0d address", i));
            checkEq(seenData[i], expData[i], $sformatf("store %0d data", i));
            checkEq(dmem[expAddr[i][8:1]], expData[i], $sformatf("memory after store %0d", i));
        end
        checkEq(16'(seenLoad.size()), 16'(expLoad.size()), "load count");
        for (i = 0; i < expLoad.size(); i++) begin
            checkEq(seenLoad[i], expLoad[i], $sformatf("load %0d address", i));
        end
        prog.delete();
        expAddr.delete();
        expData.delete();
        expLoad.delete();
        nextAddr = 16'h0000;
    endtask

    task automatic immediateOps();
        logic [15:0] a, b;
        logic [4:0]  imm;
        int n, k;
        for (n = 0; n < 2; n++) begin
            a = 16'($urandom());
            loadConst(3'd1, a);
            for (k = 0; k < 8; k++) begin
                imm = 5'($urandom());
                b = (k < 2) ? {{11{imm[4]}}, imm} : {11'd0, imm}; // Logic ops zero extend
                emit(encI1(immOps[k], 3'd1, 3'd2, imm));
                storeResult(3'd2, aluModel(k, a, b));
            end
        end
        runProgram(1'b0);
    endtask

    task automatic registerOps();
        logic [15:0] a, b;
        logic [4:0]  op;
        int k, p;
        a = 16'($urandom());
        b = 16'($urandom());
        loadConst(3'd1, a);
        loadConst(3'd2, b);
        for (k = 0; k < 8; k++) begin
            op = (k < 4) ? wiscPkg::opRArith : wiscPkg::opRShift;
            emit(encR(op, 3'd1, 3'd2, 3'd3, 2'(k)));
            storeResult(3'd3, aluModel(k, a, b));
        end
        for (p = 0; p < 5; p++) begin
            loadConst(3'd1, cmpA[p]);
            loadConst(3'd2, cmpB[p]);
            for (k = 0; k < 4; k++) begin
                emit(encR(cmpOps[k], 3'd1, 3'd2, 3'd3, 2'b00));
                storeResult(3'd3, {15'd0, compareModel(k, cmpA[p], cmpB[p])});
            end
        end
        runProgram(1'b0);
    endtask

    task automatic loadsAndStores();
        loadConst(3'd1, 16'h0120);
        emit(encI1(wiscPkg::opLd, 3'd1, 3'd2, 5'd6));  // Word 0x93
        expLoad.push_back(16'h0126);
        emit(encI1(wiscPkg::opLd, 3'd1, 3'd3, 5'h1C)); // Minus 4, word 0x8E
        expLoad.push_back(16'h011C);
        storeResult(3'd2, fillWord(8'h93));
        storeResult(3'd3, fillWord(8'h8E));
        loadConst(3'd5, 16'h0040);
        emit(encI1(wiscPkg::opSt, 3'd5, 3'd2, 5'h1E));
        expAddr.push_back(16'h003E);
        expData.push_back(fillWord(8'h93));
        emit(encI1(wiscPkg::opSt, 3'd5, 3'd3, 5'd14));
        expAddr.push_back(16'h004E);
        expData.push_back(fillWord(8'h8E));
        emit(encI1(wiscPkg::opLd, 3'd5, 3'd4, 5'h1E)); // Reads back the new word
        expLoad.push_back(16'h003E);
        storeResult(3'd4, fillWord(8'h93));
        runProgram(1'b0);
    endtask

    task automatic branchRules();
        logic [7:0] marker;
        int c;
        for (c = 0; c < 8; c++) begin
            loadConst(3'd1, brVals[c]);
            emit(encI2(brOps[c / 2], 3'd1, 8'd6));
            emit(encI2(wiscPkg::opLbi, 3'd2, 8'(8'h20 + c)));  // Fall-through path
            storeRaw(3'd2);
            emit(encJ(wiscPkg::opJ, 11'd4));
            emit(encI2(wiscPkg::opLbi, 3'd2, 8'(8'h40 + c)));  // Taken path
            storeRaw(3'd2);
            emit(encI1(wiscPkg::opAddi, 3'd6, 3'd6, 5'd2));
            marker = branchTaken(c / 2, brVals[c]) ? 8'(8'h40 + c) : 8'(8'h20 + c);
            expAddr.push_back(nextAddr);
            expData.push_back({8'h00, marker});
            nextAddr = nextAddr + 16'd2;
        end
        runProgram(1'b0);
    endtask

    task automatic jumpsAndLinks();
        logic [15:0] p;
        emit(encJ(wiscPkg::opJ, 11'd4));
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h11));
        storeRaw(3'd2);
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h22));
        storeResult(3'd2, 16'h0022);
        p = pcNext();
        emit(encJ(wiscPkg::opJal, 11'd4));
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h11));
        storeRaw(3'd2);
        storeResult(3'd7, p + 16'd2);
        p = pcNext() + 16'd4;                          // JR sits after the constant load
        loadConst(3'd1, p + 16'd2);
        emit(encI2(wiscPkg::opJr, 3'd1, 8'd4));
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h11));
        storeRaw(3'd2);
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h33));
        storeResult(3'd2, 16'h0033);
        p = pcNext() + 16'd4;
        loadConst(3'd1, p + 16'd14);
        emit(encI2(wiscPkg::opJalr, 3'd1, 8'hF8)); // Minus 8 offset
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h11));
        storeRaw(3'd2);
        storeResult(3'd7, p + 16'd2);
        runProgram(1'b0);
    endtask

    task automatic haltAndIllegal();
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h33));
        storeResult(3'd2, 16'h0033);
        emit({wiscPkg::opHalt, 11'd0});
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h44));
        storeRaw(3'd2);
        runProgram(1'b0);
        emit(encI2(wiscPkg::opLbi, 3'd2, 8'h55));
        storeResult(3'd2, 16'h0055);
        emit({5'b10011, 3'd6, 3'd2, 5'd0});            // STU is not in this core
        storeRaw(3'd2);
        runProgram(1'b1);
    endtask

    initial begin
        void'($urandom(99258));
        arstN = 1'b0;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = 16'h0000;
        end
        immediateOps();
        registerOps();
        loadsAndStores();
        branchRules();
        jumpsAndLinks();
        haltAndIllegal();
        $display("Regression passed");
        $finish;
    end

endmodule

/* list.f */
source/wiscPkg.sv
source/ctrlIf.sv
source/control.sv
source/regFile.sv
source/executeUnit.sv
source/pcUnit.sv
source/wiscCore.sv
testbench/tbWiscCore.sv

/* Makefile */
# Verilator build and run for the single-cycle core

VERILATOR ?= verilator
TOP       ?= tbWiscCore
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
